/* csr_pkg.sv */
// shared csr widths, register numbers and exception codes; no TLB registers, 32-bit data only
`default_nettype none

package csr_pkg;

    localparam int csr_num_w  = 14;
    localparam int data_w     = 32;
    localparam int ecode_w    = 6;
    localparam int esubcode_w = 9;
    localparam int hw_int_w   = 8;
    localparam int int_w      = 13; // interrupt status bits in ESTAT

    // SAVE registers sit at csr_save_base + index
    typedef enum logic [csr_num_w-1:0] {
        csr_crmd      = 14'h0,
        csr_prmd      = 14'h1,
        csr_ecfg      = 14'h4,
        csr_estat     = 14'h5,
        csr_era       = 14'h6,
        csr_badv      = 14'h7,
        csr_eentry    = 14'hc,
        csr_save_base = 14'h30,
        csr_tid       = 14'h40,
        csr_tcfg      = 14'h41,
        csr_tval      = 14'h42,
        csr_ticlr     = 14'h44
    } csr_num_e;

    // only the address error codes need decoding here
    typedef enum logic [ecode_w-1:0] {
        ecode_ade = 6'h8,
        ecode_ale = 6'h9
    } ecode_e;

    localparam logic [esubcode_w-1:0] esubcode_adef = '0; // fetch address error

    localparam logic [int_w-1:0] ecfg_lie_mask = 13'h1bff; // bit 10 reserved
    localparam int timer_int_bit = 11;

    // new bits where the mask is set and old bits elsewhere
    function automatic logic [data_w-1:0] csr_merge(
        input logic [data_w-1:0] old_value,
        input logic [data_w-1:0] wmask,
        input logic [data_w-1:0] wvalue
    );
        return (wmask & wvalue) | (~wmask & old_value);
    endfunction

endpackage

`default_nettype wire

/* csr_exc_regs.sv */
// exception csrs; wb_ex beats ertn_flush beats a csr write, ERA and BADV hold no reset value
`default_nettype none

module csr_exc_regs (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic [csr_pkg::csr_num_w-1:0]    csr_num,
    input  logic                             csr_we,
    input  logic [csr_pkg::data_w-1:0]       csr_wmask,
    input  logic [csr_pkg::data_w-1:0]       csr_wvalue,
    input  logic                             wb_ex,
    input  logic [csr_pkg::ecode_w-1:0]      wb_ecode,
    input  logic [csr_pkg::esubcode_w-1:0]   wb_esubcode,
    input  logic [csr_pkg::data_w-1:0]       wb_pc,
    input  logic [csr_pkg::data_w-1:0]       wb_vaddr,
    input  logic                             ertn_flush,
    input  logic [csr_pkg::hw_int_w-1:0]     hw_int_in,
    input  logic                             ipi_int_in,
    input  logic                             timer_int,
    output logic [csr_pkg::data_w-1:0]       rvalue,
    output logic                             has_int
);
    import csr_pkg::*;

    logic [1:0]            crmd_plv;
    logic                  crmd_ie;
    logic [1:0]            prmd_pplv;
    logic                  prmd_pie;
    logic [int_w-1:0]      ecfg_lie;
    logic [1:0]            estat_sw;   // software interrupts
    logic [hw_int_w-1:0]   estat_hw;
    logic                  estat_ipi;
    logic [int_w-1:0]      estat_is;
    logic [ecode_w-1:0]    estat_ecode;
    logic [esubcode_w-1:0] estat_esubcode;
    logic [data_w-1:0]     era_pc;
    logic [data_w-1:0]     badv_vaddr;
    logic [data_w-7:0]     eentry_va;  // 64-byte aligned entry

    logic [data_w-1:0] crmd_rvalue;
    logic [data_w-1:0] prmd_rvalue;
    logic [data_w-1:0] ecfg_rvalue;
    logic [data_w-1:0] estat_rvalue;
    logic [data_w-1:0] eentry_rvalue;
    logic [data_w-1:0] crmd_wr;
    logic [data_w-1:0] prmd_wr;
    logic [data_w-1:0] ecfg_wr;
    logic [data_w-1:0] estat_wr;
    logic [data_w-1:0] era_wr;
    logic [data_w-1:0] eentry_wr;
    logic              addr_err;

    // DA reads as 1, paging fields as 0
    assign crmd_rvalue   = {{(data_w-4){1'b0}}, 1'b1, crmd_ie, crmd_plv};
    assign prmd_rvalue   = {{(data_w-3){1'b0}}, prmd_pie, prmd_pplv};
    assign ecfg_rvalue   = {{(data_w-int_w){1'b0}}, ecfg_lie};
    assign estat_rvalue  = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
    assign eentry_rvalue = {eentry_va, 6'b0};

    // old bits of each merge come from the read view
    assign crmd_wr   = csr_merge(crmd_rvalue, csr_wmask, csr_wvalue);
    assign prmd_wr   = csr_merge(prmd_rvalue, csr_wmask, csr_wvalue);
    assign ecfg_wr   = csr_merge(ecfg_rvalue, csr_wmask, csr_wvalue);
    assign estat_wr  = csr_merge(estat_rvalue, csr_wmask, csr_wvalue);
    assign era_wr    = csr_merge(era_pc, csr_wmask, csr_wvalue);
    assign eentry_wr = csr_merge(eentry_rvalue, csr_wmask, csr_wvalue);

    always_comb begin
        estat_is                = '0;
        estat_is[1:0]           = estat_sw;
        estat_is[9:2]           = estat_hw;
        estat_is[timer_int_bit] = timer_int; // live from the timer latch
        estat_is[12]            = estat_ipi;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && csr_num == csr_crmd) begin
            crmd_plv <= crmd_wr[1:0];
            crmd_ie  <= crmd_wr[2];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin   // save state before it is cleared
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_we && csr_num == csr_prmd) begin
            prmd_pplv <= prmd_wr[1:0];
            prmd_pie  <= prmd_wr[2];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ecfg_lie  <= '0;
            estat_sw  <= 2'b0;
            estat_hw  <= '0;
            estat_ipi <= 1'b0;
            eentry_va <= '0;
        end else begin
            if (csr_we && csr_num == csr_ecfg)
                ecfg_lie <= ecfg_wr[int_w-1:0] & ecfg_lie_mask;
            if (csr_we && csr_num == csr_estat)
                estat_sw <= estat_wr[1:0];
            if (csr_we && csr_num == csr_eentry)
                eentry_va <= eentry_wr[data_w-1:6];
            estat_hw  <= hw_int_in;  // sampled every cycle
            estat_ipi <= ipi_int_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end
    end

    assign addr_err = (wb_ecode == ecode_ade) || (wb_ecode == ecode_ale);

    always_ff @(posedge clk) begin
        if (wb_ex)
            era_pc <= wb_pc;
        else if (csr_we && csr_num == csr_era)
            era_pc <= era_wr;
        if (wb_ex && addr_err)  // fetch errors report the pc itself
            badv_vaddr <= (wb_ecode == ecode_ade && wb_esubcode == esubcode_adef)
                          ? wb_pc : wb_vaddr;
    end

    always_comb begin
        case (csr_num)
            csr_crmd:   rvalue = crmd_rvalue;
            csr_prmd:   rvalue = prmd_rvalue;
            csr_ecfg:   rvalue = ecfg_rvalue;
            csr_estat:  rvalue = estat_rvalue;
            csr_era:    rvalue = era_pc;
            csr_badv:   rvalue = badv_vaddr;
            csr_eentry: rvalue = eentry_rvalue;
            default:    rvalue = '0;
        endcase
    end

    assign has_int = ((estat_is & ecfg_lie) != '0) && crmd_ie;

endmodule

`default_nettype wire

/* csr_scratch_regs.sv */
// save_num SAVE registers from csr_save_base plus TID; save_num must stay within 1 to 16
`default_nettype none

module csr_scratch_regs #(
    parameter int save_num = 4
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic [csr_pkg::csr_num_w-1:0] csr_num,
    input  logic                          csr_we,
    input  logic [csr_pkg::data_w-1:0]    csr_wmask,
    input  logic [csr_pkg::data_w-1:0]    csr_wvalue,
    output logic [csr_pkg::data_w-1:0]    rvalue
);
    import csr_pkg::*;

    logic [data_w-1:0] save_q [save_num];
    logic [data_w-1:0] save_rd [save_num]; // per-register read term
    logic [data_w-1:0] tid_q;

    for (genvar i = 0; i < save_num; i++) begin : g_save
        localparam logic [csr_num_w-1:0] addr = csr_num_w'(csr_save_base) + csr_num_w'(i);

        always_ff @(posedge clk) begin
            if (!resetn)
                save_q[i] <= '0;
            else if (csr_we && csr_num == addr)
                save_q[i] <= csr_merge(save_q[i], csr_wmask, csr_wvalue);
        end

        assign save_rd[i] = (csr_num == addr) ? save_q[i] : '0;
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            tid_q <= '0;
        else if (csr_we && csr_num == csr_tid)
            tid_q <= csr_merge(tid_q, csr_wmask, csr_wvalue);
    end

    always_comb begin
        rvalue = (csr_num == csr_tid) ? tid_q : '0;
        for (int i = 0; i < save_num; i++)
            rvalue = rvalue | save_rd[i];  // at most one hit
    end

endmodule

`default_nettype wire

/* csr_timer.sv */
// 32-bit down counter timer; TVAL is read only, TICLR reads as zero, set beats clear on timer_int
`default_nettype none

module csr_timer (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic [csr_pkg::csr_num_w-1:0] csr_num,
    input  logic                          csr_we,
    input  logic [csr_pkg::data_w-1:0]    csr_wmask,
    input  logic [csr_pkg::data_w-1:0]    csr_wvalue,
    output logic [csr_pkg::data_w-1:0]    rvalue,
    output logic                          timer_int
);
    import csr_pkg::*;

    logic              tcfg_en;
    logic              tcfg_periodic;
    logic [data_w-3:0] tcfg_initval;   // counter start is initval * 4
    logic [data_w-1:0] tcfg_rvalue;
    logic [data_w-1:0] tcfg_next;      // TCFG after this cycle's write
    logic [data_w-1:0] timer_cnt;
    logic              tcfg_wr;
    logic              ticlr_clr;
    logic              cnt_zero;
    logic              cnt_idle;

    assign tcfg_rvalue = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_next   = csr_merge(tcfg_rvalue, csr_wmask, csr_wvalue);
    assign tcfg_wr     = csr_we && csr_num == csr_tcfg;
    assign ticlr_clr   = csr_we && csr_num == csr_ticlr && csr_wmask[0] && csr_wvalue[0];

    assign cnt_zero = (timer_cnt == '0);
    assign cnt_idle = (timer_cnt == '1);  // one-shot has expired

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (tcfg_wr) begin
            tcfg_en       <= tcfg_next[0];
            tcfg_periodic <= tcfg_next[1];
            tcfg_initval  <= tcfg_next[data_w-1:2];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            timer_cnt <= '1;
        end else if (tcfg_wr && tcfg_next[0]) begin
            timer_cnt <= {tcfg_next[data_w-1:2], 2'b0};  // load on enabling write
        end else if (tcfg_en && !cnt_idle) begin
            if (cnt_zero && tcfg_periodic)
                timer_cnt <= {tcfg_initval, 2'b0};
            else
                timer_cnt <= timer_cnt - data_w'(1);  // one-shot wraps to all-ones and stops
        end
    end

    // interrupt latch
    always_ff @(posedge clk) begin
        if (!resetn)
            timer_int <= 1'b0;
        else if (cnt_zero)
            timer_int <= 1'b1;
        else if (ticlr_clr)
            timer_int <= 1'b0;
    end

    always_comb begin
        case (csr_num)
            csr_tcfg: rvalue = tcfg_rvalue;
            csr_tval: rvalue = timer_cnt;
            default:  rvalue = '0;  // TICLR included
        endcase
    end

endmodule

`default_nettype wire

/* csr_file.sv */
// csr block top; reads are combinational with no read strobe, unmapped numbers read as zero
`default_nettype none

module csr_file #(
    parameter int save_num = 4
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic [csr_pkg::csr_num_w-1:0]    csr_num,
    input  logic                             csr_we,
    input  logic [csr_pkg::data_w-1:0]       csr_wmask,
    input  logic [csr_pkg::data_w-1:0]       csr_wvalue,
    output logic [csr_pkg::data_w-1:0]       csr_rvalue,
    input  logic                             wb_ex,
    input  logic [csr_pkg::ecode_w-1:0]      wb_ecode,
    input  logic [csr_pkg::esubcode_w-1:0]   wb_esubcode,
    input  logic [csr_pkg::data_w-1:0]       wb_pc,
    input  logic [csr_pkg::data_w-1:0]       wb_vaddr,
    input  logic                             ertn_flush,
    input  logic [csr_pkg::hw_int_w-1:0]     hw_int_in,
    input  logic                             ipi_int_in,
    output logic                             has_int
);
    import csr_pkg::*;

    logic [data_w-1:0] exc_rvalue;
    logic [data_w-1:0] scratch_rvalue;
    logic [data_w-1:0] timer_rvalue;
    logic              timer_int;   // timer to ESTAT bit 11

    csr_exc_regs exc_regs_inst (
        .clk         (clk),
        .resetn      (resetn),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .ertn_flush  (ertn_flush),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .timer_int   (timer_int),
        .rvalue      (exc_rvalue),
        .has_int     (has_int)
    );

    csr_scratch_regs #(
        .save_num (save_num)
    ) scratch_regs_inst (
        .clk        (clk),
        .resetn     (resetn),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .rvalue     (scratch_rvalue)
    );

    csr_timer timer_inst (
        .clk        (clk),
        .resetn     (resetn),
        .csr_num    (csr_num),
        .csr_we     (csr_we),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .rvalue     (timer_rvalue),
        .timer_int  (timer_int)
    );

    // each leaf drives zero unless the number is its own
    assign csr_rvalue = exc_rvalue | scratch_rvalue | timer_rvalue;

endmodule

`default_nettype wire

/* csr_file_checker.sv */
// assertions bound into csr_exc_regs and csr_timer; each bind ties the ports it has no use for to 0
`default_nettype none

module csr_file_checker (
    input logic       clk,
    input logic       resetn,
    input logic       wb_ex,
    input logic [1:0] crmd_plv,
    input logic       crmd_ie,
    input logic       has_int,
    input logic       timer_int,
    input logic       ticlr_clr
);
    timeunit 1ns;
    timeprecision 1ps;

    // exception entry drops to plv 0 with interrupts off
    exc_clears_crmd: assert property (@(posedge clk) disable iff (!resetn)
        wb_ex |=> (crmd_plv == 2'b0 && !crmd_ie))
        else $error("CRMD plv or ie not cleared after an exception");

    int_needs_ie: assert property (@(posedge clk) disable iff (!resetn)
        has_int |-> crmd_ie)
        else $error("has_int raised while CRMD ie is 0");

    timer_int_held: assert property (@(posedge clk) disable iff (!resetn)
        (timer_int && !ticlr_clr) |=> timer_int)  // only TICLR clears it
        else $error("timer interrupt dropped without a TICLR clear");

endmodule

bind csr_exc_regs csr_file_checker exc_checker_inst (
    .clk       (clk),
    .resetn    (resetn),
    .wb_ex     (wb_ex),
    .crmd_plv  (crmd_plv),
    .crmd_ie   (crmd_ie),
    .has_int   (has_int),
    .timer_int (1'b0),
    .ticlr_clr (1'b0)
);

bind csr_timer csr_file_checker timer_checker_inst (
    .clk       (clk),
    .resetn    (resetn),
    .wb_ex     (1'b0),
    .crmd_plv  (2'b0),
    .crmd_ie   (1'b0),
    .has_int   (1'b0),
    .timer_int (timer_int),
    .ticlr_clr (ticlr_clr)
);

`default_nettype wire

/* tb_csr_file.sv */
// replays csr_vectors.mem on csr_file; at most 128 operations, an opcode 0 line ends the list
`default_nettype none

module tb_csr_file;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_vec   = 128;
    localparam int rec_words = 8;   // hex words per vector line

    localparam logic [31:0] op_end    = 32'h0;
    localparam logic [31:0] op_write  = 32'h1;
    localparam logic [31:0] op_read   = 32'h2;
    localparam logic [31:0] op_exc    = 32'h3;
    localparam logic [31:0] op_ertn   = 32'h4;
    localparam logic [31:0] op_ints   = 32'h5;
    localparam logic [31:0] op_wait   = 32'h6;
    localparam logic [31:0] op_hasint = 32'h7;

    // field order matches the columns of the vector file
    typedef struct packed {
        logic [31:0] op;
        logic [31:0] num;       // ecode for an exception
        logic [31:0] mask;      // esubcode for an exception
        logic [31:0] value;     // cycle count for a wait
        logic [31:0] pc;
        logic [31:0] vaddr;
        logic [31:0] ints;      // {ipi, hw[7:0]}
        logic [31:0] expected;
    } vec_rec_t;

    logic [31:0] raw [max_vec*rec_words];
    vec_rec_t    vecs [max_vec];
    int          num_vec;
    int          wait_sum;
    int          cycle_limit = 1000000;  // replaced once the vectors are loaded
    int          cycles;
    int          checks;
    int          errors;

    logic        clk;
    logic        resetn;
    logic [13:0] csr_num;
    logic        csr_we;
    logic [31:0] csr_wmask;
    logic [31:0] csr_wvalue;
    logic [31:0] csr_rvalue;
    logic        wb_ex;
    logic [5:0]  wb_ecode;
    logic [8:0]  wb_esubcode;
    logic [31:0] wb_pc;
    logic [31:0] wb_vaddr;
    logic        ertn_flush;
    logic [7:0]  hw_int_in;
    logic        ipi_int_in;
    logic        has_int;

    csr_file #(
        .save_num (4)
    ) csr_file_inst (
        .clk         (clk),
        .resetn      (resetn),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .csr_rvalue  (csr_rvalue),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .ertn_flush  (ertn_flush),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .has_int     (has_int)
    );

    always #4 clk = ~clk;

    task automatic load_vectors();
        int b;
        num_vec  = 0;
        wait_sum = 0;
        for (int i = 0; i < max_vec; i++) begin
            b = i * rec_words;
            vecs[i] = {raw[b], raw[b+1], raw[b+2], raw[b+3],
                       raw[b+4], raw[b+5], raw[b+6], raw[b+7]};
        end
        while (num_vec < max_vec && vecs[num_vec].op != op_end) begin
            if (vecs[num_vec].op == op_wait)
                wait_sum += int'(vecs[num_vec].value);
            num_vec++;
        end
    endtask

    // one operation per falling edge, strobes last a single cycle
    task automatic run_vector(input vec_rec_t v, input int idx);
        @(negedge clk);
        csr_we     = 1'b0;
        wb_ex      = 1'b0;
        ertn_flush = 1'b0;
        case (v.op)
            op_write: begin
                csr_num    = v.num[13:0];
                csr_wmask  = v.mask;
                csr_wvalue = v.value;
                csr_we     = 1'b1;
            end
            op_read: begin
                csr_num = v.num[13:0];
                #2;  // read path is combinational
                checks++;
                if (csr_rvalue !== v.expected) begin
                    errors++;
                    $display("FAIL t=%0t csr_rvalue (csr %h) expected %h got %h",
                             $time, v.num[13:0], v.expected, csr_rvalue);
                end
            end
            op_exc: begin
                wb_ecode    = v.num[5:0];
                wb_esubcode = v.mask[8:0];
                wb_pc       = v.pc;
                wb_vaddr    = v.vaddr;
                wb_ex       = 1'b1;
            end
            op_ertn: ertn_flush = 1'b1;
            op_ints: begin
                hw_int_in  = v.ints[7:0];
                ipi_int_in = v.ints[8];
            end
            op_wait: begin
                for (int k = 1; k < int'(v.value); k++)
                    @(negedge clk);
            end
            op_hasint: begin
                #2;
                checks++;
                if (has_int !== v.expected[0]) begin
                    errors++;
                    $display("FAIL t=%0t has_int expected %b got %b",
                             $time, v.expected[0], has_int);
                end
            end
            default: begin
                errors++;
                $display("vector %0d has an unknown opcode %h", idx, v.op);
            end
        endcase
    endtask

    initial begin
        clk         = 1'b0;
        resetn      = 1'b0;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        ertn_flush  = 1'b0;
        hw_int_in   = '0;
        ipi_int_in  = 1'b0;
        checks      = 0;
        errors      = 0;
        for (int i = 0; i < max_vec * rec_words; i++)
            raw[i] = '0;
        $readmemh("csr_vectors.mem", raw);
        load_vectors();
        cycle_limit = wait_sum + num_vec + 50;
        if (num_vec == 0) begin
            errors++;
            $display("no vectors were read from csr_vectors.mem");
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        for (int i = 0; i < num_vec; i++)
            run_vector(vecs[i], i);
        @(negedge clk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: vectors did not finish");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* csr_vectors.mem */
// columns: op num mask value pc vaddr ints expected, all hex; ints is {ipi, hw[7:0]}
// op 1 write 2 read 3 exception (ecode in num, subcode in mask) 4 ertn 5 ints 6 wait 7 has_int 0 end
// masked writes
1 0030 ffffffff 12345678 0 0 0 0
1 0030 0000ffff aaaabbbb 0 0 0 0
2 0030 0 0 0 0 0 1234bbbb
1 0033 f0f0f0f0 deadbeef 0 0 0 0
2 0033 0 0 0 0 0 d0a0b0e0
1 0040 00ff00ff 13572468 0 0 0 0
2 0040 0 0 0 0 0 00570068
1 000c ffff00ff 1c00abff 0 0 0 0
2 000c 0 0 0 0 0 1c0000c0
1 0004 0000ffff 00001fff 0 0 0 0
2 0004 0 0 0 0 0 00001bff
2 0043 0 0 0 0 0 00000000
// exception entry and return
1 0000 ffffffff 00000007 0 0 0 0
3 0009 00000000 0 1c000100 12345677 0 0
2 0000 0 0 0 0 0 00000008
2 0001 0 0 0 0 0 00000007
2 0006 0 0 0 0 0 1c000100
2 0007 0 0 0 0 0 12345677
2 0005 0 0 0 0 0 00090000
4 0000 0 0 0 0 0 0
2 0000 0 0 0 0 0 0000000f
3 0008 00000000 0 1c000200 99999999 0 0
2 0007 0 0 0 0 0 1c000200
// one-shot timer, initval 5
1 0041 ffffffff 00000015 0 0 0 0
2 0042 0 0 0 0 0 00000014
6 0000 0 00000012 0 0 0 0
2 0042 0 0 0 0 0 00000001
2 0042 0 0 0 0 0 00000000
2 0005 0 0 0 0 0 00080800
2 0042 0 0 0 0 0 ffffffff
// periodic timer, initval 2
1 0041 ffffffff 0000000b 0 0 0 0
6 0000 0 00000007 0 0 0 0
2 0042 0 0 0 0 0 00000001
2 0042 0 0 0 0 0 00000000
2 0042 0 0 0 0 0 00000008
1 0044 00000001 00000001 0 0 0 0
2 0005 0 0 0 0 0 00080000
1 0041 ffffffff 00000000 0 0 0 0
// interrupt lines and enables
5 0000 0 0 0 0 00000155 0
1 0004 ffffffff 00000008 0 0 0 0
1 0000 00000004 00000004 0 0 0 0
7 0000 0 0 0 0 0 00000000
2 0005 0 0 0 0 0 00081154
1 0004 ffffffff 00000004 0 0 0 0
7 0000 0 0 0 0 0 00000001
1 0000 00000004 00000000 0 0 0 0
7 0000 0 0 0 0 0 00000000
1 0000 00000004 00000004 0 0 0 0
5 0000 0 0 0 0 00000000 0
7 0000 0 0 0 0 0 00000000
1 0004 ffffffff 00001000 0 0 0 0
5 0000 0 0 0 0 00000100 0
7 0000 0 0 0 0 0 00000001
0 0000 0 0 0 0 0 0

/* build.f */
csr_pkg.sv
csr_exc_regs.sv
csr_scratch_regs.sv
csr_timer.sv
csr_file.sv
csr_file_checker.sv
tb_csr_file.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_csr_file -Mdir obj_dir -f build.f
out=$(./obj_dir/Vtb_csr_file)
echo "$out"
if echo "$out" | grep -q "^=== PASS ===$"; then
    exit 0
fi
exit 1
